//--- rtl/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

	// Command bytes
	localparam logic [7:0] CMD_VERSION = 8'h76;
	localparam logic [7:0] CMD_QUERY = 8'h51;
	localparam logic [7:0] CMD_SET = 8'h71;

	// Response codes
	localparam logic [7:0] RESP_ACK = 8'h06;
	localparam logic [7:0] RESP_NAK = 8'h15;

	localparam logic [7:0] VERSION_MAJOR = 8'h00;
	localparam logic [7:0] VERSION_MINOR = 8'h02;

	localparam int NUM_PARAMS = 4;
	localparam int PARAM_BYTES = 3;

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	typedef logic [NUM_PARAMS-1:0][8*PARAM_BYTES-1:0] cfg_settings_t;

	// Slot 0 sits in the low word
	localparam cfg_settings_t PARAM_RESET = {24'h0000AE, 24'h30D400, 24'h00FFFF, 24'h000063};

	typedef struct packed {
		logic [7:0] data;
		logic last;
	} byte_beat_t;

	typedef enum logic [1:0] {F_CMD, F_EID, F_LEN, F_PAY} field_t;

	typedef struct packed {
		logic [7:0] data;
		field_t field;
		logic last;
	} rx_field_t;

	// Shared write bus to all parameter slots
	typedef struct packed {
		logic load;
		logic commit;
		logic [1:0] index;
		logic [7:0] data;
	} slot_wr_t;

endpackage

`default_nettype wire

//--- rtl/frame_rx.sv
`default_nettype none

module frame_rx
	import cfg_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic in_valid,
	output logic in_ready,
	input byte_beat_t in_beat,

	output logic rx_valid,
	input logic rx_ready,
	output rx_field_t rx
);

	// Position of the current byte within its frame
	logic [1:0] byte_cnt;
	logic fire;

	assign fire = in_valid & rx_ready;

	// No storage on this path, so flow control passes straight through
	assign in_ready = rx_ready;
	assign rx_valid = in_valid;

	assign rx = '{
		data: in_beat.data,
		field: field_t'(byte_cnt),
		last: in_beat.last
	};

	// Counter sticks at the payload tag until the frame ends
	always_ff @(posedge clk) begin
		if (rst) begin
			byte_cnt <= 2'd0;
		end else if (fire) begin
			if (in_beat.last)
				byte_cnt <= 2'd0;
			else if (byte_cnt != 2'd3)
				byte_cnt <= byte_cnt + 2'd1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/param_slot.sv
`default_nettype none

module param_slot
	import cfg_pkg::*;
#(
	parameter int INDEX = 0
) (
	input logic clk,
	input logic rst,
	input slot_wr_t wr,
	output logic [8*PARAM_BYTES-1:0] value
);

	logic [8*PARAM_BYTES-1:0] shadow;
	logic hit;

	assign hit = (wr.index == 2'(INDEX));

	// Set data arrives most significant byte first
	always_ff @(posedge clk) begin
		if (hit && wr.load)
			shadow <= {shadow[8*PARAM_BYTES-9:0], wr.data};
	end

	always_ff @(posedge clk) begin
		if (rst)
			value <= PARAM_RESET[INDEX];
		else if (hit && wr.commit)
			value <= shadow;
	end

	// Engine finishes shifting long before it commits
	assert property (@(posedge clk) disable iff (rst) !(wr.load && wr.commit))
		else $error("param_slot %0d: load and commit in the same cycle", INDEX);

endmodule

`default_nettype wire

//--- rtl/ack_generator.sv
`default_nettype none

module ack_generator
	import cfg_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic hdr_start,
	input logic [7:0] hdr_code,
	input logic [7:0] hdr_eid,
	output logic hdr_done,

	output logic hdr_valid,
	input logic hdr_ready,
	output byte_beat_t hdr_beat
);

	logic busy;
	// Low while on the code byte, high on the eid byte
	logic phase;
	logic [7:0] code_q;
	logic [7:0] eid_q;
	logic fire;

	assign hdr_valid = busy;
	assign fire = hdr_valid & hdr_ready;
	assign hdr_done = fire & phase;

	// last flags the end of the header; the top level decides if it closes the frame
	assign hdr_beat = '{data: phase ? eid_q : code_q, last: phase};

	always_ff @(posedge clk) begin
		if (hdr_start) begin
			code_q <= hdr_code;
			eid_q <= hdr_eid;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			phase <= 1'b0;
		end else if (hdr_start) begin
			busy <= 1'b1;
			phase <= 1'b0;
		end else if (fire) begin
			if (phase)
				busy <= 1'b0;
			phase <= ~phase;
		end
	end

	// Engine waits for hdr_done before asking for another header
	assert property (@(posedge clk) disable iff (rst) hdr_start |-> !busy)
		else $error("ack_generator: header requested while busy");

endmodule

`default_nettype wire

//--- rtl/msg_fifo.sv
`default_nettype none

module msg_fifo
	import cfg_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic wr_valid,
	output logic wr_ready,
	input byte_beat_t wr_beat,

	output logic out_valid,
	input logic out_ready,
	output byte_beat_t out_beat,
	output logic frame_sent
);

	byte_beat_t mem [FIFO_DEPTH];

	// Pointers carry one extra wrap bit
	logic [FIFO_AW:0] wp, rp, cp;
	logic [FIFO_AW:0] used;
	logic [FIFO_AW:0] wp_step;
	logic [FIFO_AW-1:0] len_ptr;
	logic [FIFO_AW-1:0] wp_addr;
	logic [1:0] wpos;
	logic [7:0] pay_cnt;
	logic wr_fire;
	logic rd_fire;

	assign used = wp - rp;
	assign wp_addr = wp[FIFO_AW-1:0];

	// Eid write also reserves the length slot behind it
	assign wp_step = (wpos == 2'd1) ? (FIFO_AW+1)'(2) : (FIFO_AW+1)'(1);

	// Frame gate: room for a whole frame before its code byte is taken
	assign wr_ready = (wpos != 2'd0) || (used <= (FIFO_AW+1)'(FIFO_DEPTH - 7));
	assign wr_fire = wr_valid & wr_ready;

	// Only bytes of completed frames are visible
	assign out_valid = (rp != cp);
	assign out_beat = mem[rp[FIFO_AW-1:0]];
	assign rd_fire = out_valid & out_ready;
	assign frame_sent = rd_fire & out_beat.last;

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			if (wpos == 2'd1) begin
				mem[wp_addr] <= '{data: wr_beat.data, last: 1'b0};
				// Empty response ends on its length byte
				mem[wp_addr + 1'b1] <= '{data: 8'h00, last: wr_beat.last};
				len_ptr <= wp_addr + 1'b1;
			end else begin
				mem[wp_addr] <= wr_beat;
				if (wpos == 2'd2 && wr_beat.last)
					mem[len_ptr] <= '{data: pay_cnt + 8'd1, last: 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wp <= '0;
			rp <= '0;
			cp <= '0;
			wpos <= 2'd0;
			pay_cnt <= 8'd0;
		end else begin
			if (wr_fire) begin
				wp <= wp + wp_step;
				if (wr_beat.last) begin
					cp <= wp + wp_step;
					wpos <= 2'd0;
					pay_cnt <= 8'd0;
				end else if (wpos != 2'd2) begin
					wpos <= wpos + 2'd1;
				end else begin
					pay_cnt <= pay_cnt + 8'd1;
				end
			end
			if (rd_fire)
				rp <= rp + 1'b1;
		end
	end

	// Gate must leave room for every byte of the frame in flight
	assert property (@(posedge clk) disable iff (rst)
		wr_fire |-> (used + wp_step) <= (FIFO_AW+1)'(FIFO_DEPTH))
		else $error("msg_fifo: write accepted while full");

endmodule

`default_nettype wire

//--- rtl/cmd_engine.sv
`default_nettype none

module cmd_engine
	import cfg_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic rx_valid,
	output logic rx_ready,
	input rx_field_t rx,

	output slot_wr_t slot_wr,
	input cfg_settings_t settings,

	output logic hdr_start,
	output logic [7:0] hdr_code,
	output logic [7:0] hdr_eid,
	input logic hdr_done,

	output logic pay_valid,
	input logic pay_ready,
	output byte_beat_t pay_beat,

	input logic frame_sent
);

	typedef enum logic [2:0] {S_RX, S_HDR, S_HDRW, S_OUT, S_WAIT} state_t;

	state_t state;
	logic [7:0] cmd;
	logic [7:0] eid;
	logic [7:0] sel;
	logic [15:0] ver_in;
	logic [2:0] cnt;
	logic [1:0] out_cnt;
	// Response frames queued in the FIFO and not yet sent
	logic [2:0] pend;
	logic rx_fire;
	logic pay_byte;
	logic known;
	logic sel_ok;
	logic ver_ok;
	logic resp_ack;
	logic [1:0] resp_len;
	logic [8*PARAM_BYTES-1:0] sel_value;

	assign rx_ready = (state == S_RX);
	assign rx_fire = rx_valid & rx_ready;
	assign pay_byte = rx_fire && (rx.field == F_PAY);

	assign known = (cmd == CMD_VERSION) || (cmd == CMD_QUERY) || (cmd == CMD_SET);
	assign sel_ok = (sel < 8'(NUM_PARAMS));
	assign ver_ok = (ver_in == {VERSION_MAJOR, VERSION_MINOR});

	// Response code and payload size
	always_comb begin
		resp_ack = sel_ok;
		resp_len = 2'd0;
		if (cmd == CMD_VERSION) begin
			resp_ack = ver_ok;
			resp_len = ver_ok ? 2'd0 : 2'd2;
		end else if (cmd == CMD_QUERY && sel_ok) begin
			resp_len = 2'(PARAM_BYTES);
		end
	end

	assign hdr_start = (state == S_HDR);
	assign hdr_code = resp_ack ? RESP_ACK : RESP_NAK;
	assign hdr_eid = eid;

	// Readback, MSB first
	assign sel_value = settings[sel[1:0]];
	assign pay_valid = (state == S_OUT);
	always_comb begin
		if (cmd == CMD_VERSION)
			pay_beat.data = (out_cnt == 2'd0) ? VERSION_MAJOR : VERSION_MINOR;
		else
			pay_beat.data = sel_value[8*(PARAM_BYTES-1-int'(out_cnt)) +: 8];
		// Outside S_OUT this tells the header merge that no payload follows
		if (state == S_OUT)
			pay_beat.last = (out_cnt == resp_len - 2'd1);
		else
			pay_beat.last = (resp_len == 2'd0);
	end

	// Bytes 1..3 of a set payload go to the chosen shadow
	assign slot_wr.load = pay_byte && (cmd == CMD_SET) && sel_ok &&
		(cnt != 3'd0) && (cnt <= 3'(PARAM_BYTES));
	assign slot_wr.commit = (state == S_WAIT) && frame_sent && (pend == 3'd1);
	assign slot_wr.index = sel[1:0];
	assign slot_wr.data = rx.data;

	always_ff @(posedge clk) begin
		if (rx_fire) begin
			case (rx.field)
				F_CMD: cmd <= rx.data;
				F_EID: eid <= rx.data;
				F_LEN: ver_in <= 16'h0000;
				default: begin
					if (cnt == 3'd0)
						sel <= rx.data;
					ver_in <= {ver_in[7:0], rx.data};
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_RX;
			cnt <= 3'd0;
			out_cnt <= 2'd0;
			pend <= 3'd0;
		end else begin
			pend <= pend + 3'(hdr_done) - 3'(frame_sent);
			if (rx_fire && rx.field == F_LEN)
				cnt <= 3'd0;
			else if (pay_byte && cnt != 3'd4)
				cnt <= cnt + 3'd1;
			case (state)
				S_RX: begin
					// Unknown commands just run out to their last byte
					if (pay_byte && rx.last && known)
						state <= S_HDR;
				end
				S_HDR: begin
					out_cnt <= 2'd0;
					state <= S_HDRW;
				end
				S_HDRW: begin
					if (hdr_done) begin
						if (resp_len != 2'd0)
							state <= S_OUT;
						else if (cmd == CMD_SET && sel_ok)
							state <= S_WAIT;
						else
							state <= S_RX;
					end
				end
				S_OUT: begin
					if (pay_ready) begin
						out_cnt <= out_cnt + 2'd1;
						if (pay_beat.last)
							state <= S_RX;
					end
				end
				// Hold input until the ACK has left the output port
				S_WAIT: begin
					if (slot_wr.commit)
						state <= S_RX;
				end
				default: state <= S_RX;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/cfg_top.sv
`default_nettype none

module cfg_top
	import cfg_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic in_valid,
	output logic in_ready,
	input byte_beat_t in_beat,

	output logic out_valid,
	input logic out_ready,
	output byte_beat_t out_beat,

	output cfg_settings_t settings
);

	logic rx_valid, rx_ready;
	rx_field_t rx;
	slot_wr_t slot_wr;

	logic hdr_start, hdr_done;
	logic [7:0] hdr_code, hdr_eid;
	logic hdr_valid, hdr_ready;
	byte_beat_t hdr_beat;

	logic pay_valid, pay_ready;
	byte_beat_t pay_beat;

	logic wr_valid, wr_ready;
	byte_beat_t wr_beat;
	logic frame_sent;

	frame_rx u_frame_rx (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_beat(in_beat),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.rx(rx)
	);

	cmd_engine u_cmd_engine (
		.clk(clk),
		.rst(rst),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.rx(rx),
		.slot_wr(slot_wr),
		.settings(settings),
		.hdr_start(hdr_start),
		.hdr_code(hdr_code),
		.hdr_eid(hdr_eid),
		.hdr_done(hdr_done),
		.pay_valid(pay_valid),
		.pay_ready(pay_ready),
		.pay_beat(pay_beat),
		.frame_sent(frame_sent)
	);

	for (genvar i = 0; i < NUM_PARAMS; i++) begin : g_slot
		param_slot #(.INDEX(i)) u_slot (
			.clk(clk),
			.rst(rst),
			.wr(slot_wr),
			.value(settings[i])
		);
	end

	ack_generator u_ack_generator (
		.clk(clk),
		.rst(rst),
		.hdr_start(hdr_start),
		.hdr_code(hdr_code),
		.hdr_eid(hdr_eid),
		.hdr_done(hdr_done),
		.hdr_valid(hdr_valid),
		.hdr_ready(hdr_ready),
		.hdr_beat(hdr_beat)
	);

	// FIFO write port, header first
	assign wr_valid = hdr_valid | pay_valid;
	assign hdr_ready = wr_ready;
	assign pay_ready = wr_ready & ~hdr_valid;

	// Eid byte closes the frame only when the engine has no payload to add
	always_comb begin
		if (hdr_valid)
			wr_beat = '{data: hdr_beat.data, last: hdr_beat.last & pay_beat.last};
		else
			wr_beat = pay_beat;
	end

	msg_fifo u_msg_fifo (
		.clk(clk),
		.rst(rst),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready),
		.wr_beat(wr_beat),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_beat(out_beat),
		.frame_sent(frame_sent)
	);

endmodule

`default_nettype wire

//--- verif/tb_cfg_top.sv
`default_nettype none

module tb_cfg_top
	import cfg_pkg::*;
();

	localparam int HALF_PERIOD = 20;
	localparam int DRIVE_DLY = 5;
	localparam int WAIT_LIMIT = 400;
	localparam int SOAK_LEN = 20;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	byte_beat_t in_beat;
	logic out_valid;
	logic out_ready;
	byte_beat_t out_beat;
	cfg_settings_t settings;

	logic [31:0] lfsr;
	// Bytes of the frame being sent
	logic [7:0] frame_q[$];
	byte_beat_t got_q[$];
	// Expected contents of the four slots
	cfg_settings_t model;
	int checks;
	int value_errors;
	int other_errors;

	cfg_top uut (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_beat(in_beat),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_beat(out_beat),
		.settings(settings)
	);

	always #HALF_PERIOD clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	task automatic finish_run();
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		other_errors++;
	endtask

	task automatic check_beat(input string name, input byte_beat_t exp, input byte_beat_t act);
		checks++;
		if (act !== exp) begin
			$display("** Error %s: expected data %h last %b, actual data %h last %b",
				name, exp.data, exp.last, act.data, act.last);
			value_errors++;
		end
	endtask

	task automatic check_settings(input string name, input cfg_settings_t exp,
		input cfg_settings_t act);
		checks++;
		if (act !== exp) begin
			$display("** Error %s: expected settings %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_len(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			$display("** Error %s: expected length %0d, actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	// Header of two bytes, length byte, then n payload bytes MSB first
	task automatic build_frame(input logic [7:0] first, input logic [7:0] eid, input int n,
		input logic [31:0] pay);
		frame_q.delete();
		frame_q.push_back(first);
		frame_q.push_back(eid);
		frame_q.push_back(8'(n));
		for (int k = 0; k < n; k++)
			frame_q.push_back(pay[8*(n-1-k) +: 8]);
	endtask

	// Starts and ends a little after a rising edge
	task automatic send_frame();
		int cycles;
		for (int i = 0; i < frame_q.size(); i++) begin
			in_valid = 1'b1;
			in_beat = '{data: frame_q[i], last: (i == frame_q.size() - 1)};
			cycles = 0;
			@(negedge clk);
			while (!in_ready && cycles < WAIT_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			if (!in_ready)
				report_timeout("input stream never accepted a byte");
			@(posedge clk);
			#DRIVE_DLY;
		end
		in_valid = 1'b0;
		in_beat = '0;
	endtask

	// Random out_ready while collecting one frame
	task automatic recv_frame();
		int cycles;
		logic done;
		got_q.delete();
		done = 1'b0;
		cycles = 0;
		while (!done && cycles < WAIT_LIMIT) begin
			out_ready = 1'(rand_bits(1));
			@(negedge clk);
			if (out_valid && out_ready) begin
				got_q.push_back(out_beat);
				done = out_beat.last;
			end
			@(posedge clk);
			#DRIVE_DLY;
			cycles++;
		end
		out_ready = 1'b0;
		if (!done)
			report_timeout("no complete response frame at the output");
	endtask

	// Code, eid, payload count, then the payload MSB first
	task automatic compare_frame(input string name, input logic [7:0] code,
		input logic [7:0] eid, input int n, input logic [31:0] pay);
		byte_beat_t exp;
		check_len(name, n + 3, got_q.size());
		for (int i = 0; i < n + 3 && i < got_q.size(); i++) begin
			if (i == 0)
				exp.data = code;
			else if (i == 1)
				exp.data = eid;
			else if (i == 2)
				exp.data = 8'(n);
			else
				exp.data = pay[8*(n+2-i) +: 8];
			exp.last = (i == n + 2);
			check_beat(name, exp, got_q[i]);
		end
	endtask

	task automatic transact(input string name, input logic [7:0] cmd, input logic [7:0] eid,
		input int tx_len, input logic [31:0] tx_pay, input logic [7:0] code,
		input int rx_len, input logic [31:0] rx_pay);
		build_frame(cmd, eid, tx_len, tx_pay);
		send_frame();
		recv_frame();
		compare_frame(name, code, eid, rx_len, rx_pay);
	endtask

	task automatic version_test();
		transact("version match", CMD_VERSION, 8'h21, 2, 32'h0002, RESP_ACK, 0, 32'h0);
		transact("version mismatch", CMD_VERSION, 8'h21, 2, 32'h0105, RESP_NAK, 2, 32'h0002);
	endtask

	task automatic query_reset_test();
		for (int s = 0; s < NUM_PARAMS; s++)
			transact($sformatf("query reset %0d", s), CMD_QUERY, 8'h40 + 8'(s), 1, 32'(s),
				RESP_ACK, 3, 32'(model[s]));
	endtask

	task automatic set_query_test();
		int cycles;
		build_frame(CMD_SET, 8'h33, 4, 32'h02ABCDEF);
		send_frame();
		// Frame sits complete in the FIFO with the output stalled
		cycles = 0;
		@(negedge clk);
		while (!out_valid && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!out_valid)
			report_timeout("set response never became visible");
		@(posedge clk);
		#DRIVE_DLY;
		check_settings("set before send", model, settings);
		recv_frame();
		compare_frame("set ack", RESP_ACK, 8'h33, 0, 32'h0);
		model[2] = 24'hABCDEF;
		check_settings("set after send", model, settings);
		transact("query after set", CMD_QUERY, 8'h34, 1, 32'h2, RESP_ACK, 3, 32'hABCDEF);
	endtask

	task automatic bad_input_test();
		logic seen;
		transact("bad selector", CMD_QUERY, 8'h55, 1, 32'h7, RESP_NAK, 0, 32'h0);
		build_frame(8'h99, 8'h56, 1, 32'h0);
		send_frame();
		seen = 1'b0;
		out_ready = 1'b1;
		repeat (25) begin
			@(negedge clk);
			if (out_valid)
				seen = 1'b1;
			@(posedge clk);
			#DRIVE_DLY;
		end
		out_ready = 1'b0;
		if (seen) begin
			$display("Error: an output frame appeared for an unknown command");
			other_errors++;
		end
		transact("query after unknown", CMD_QUERY, 8'h57, 1, 32'h1, RESP_ACK, 3,
			32'(model[1]));
	endtask

	task automatic soak_test();
		logic op;
		logic [2:0] sel;
		logic [23:0] val;
		logic [7:0] cmd [SOAK_LEN];
		logic [7:0] eid [SOAK_LEN];
		int tx_len [SOAK_LEN];
		logic [31:0] tx_pay [SOAK_LEN];
		logic [7:0] code [SOAK_LEN];
		int rx_len [SOAK_LEN];
		logic [31:0] rx_pay [SOAK_LEN];
		cfg_settings_t snap [SOAK_LEN];
		// All frames drawn up front, with the slot contents expected after each
		for (int i = 0; i < SOAK_LEN; i++) begin
			op = 1'(rand_bits(1));
			sel = 3'(rand_bits(3));
			eid[i] = 8'(rand_bits(8));
			code[i] = (sel < 3'd4) ? RESP_ACK : RESP_NAK;
			rx_len[i] = 0;
			rx_pay[i] = 32'h0;
			if (op) begin
				val = 24'(rand_bits(24));
				cmd[i] = CMD_SET;
				tx_len[i] = 4;
				tx_pay[i] = {5'd0, sel, val};
				if (sel < 3'd4)
					model[sel[1:0]] = val;
			end else begin
				cmd[i] = CMD_QUERY;
				tx_len[i] = 1;
				tx_pay[i] = 32'(sel);
				if (sel < 3'd4) begin
					rx_len[i] = 3;
					rx_pay[i] = 32'(model[sel[1:0]]);
				end
			end
			snap[i] = model;
		end
		// Sender runs ahead of the receiver so the FIFO fills under back-pressure
		fork
			for (int i = 0; i < SOAK_LEN; i++) begin
				build_frame(cmd[i], eid[i], tx_len[i], tx_pay[i]);
				send_frame();
			end
			for (int j = 0; j < SOAK_LEN; j++) begin
				recv_frame();
				compare_frame($sformatf("soak %0d", j), code[j], eid[j], rx_len[j],
					rx_pay[j]);
				check_settings($sformatf("soak %0d settings", j), snap[j], settings);
			end
		join
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_beat = '0;
		out_ready = 1'b0;
		lfsr = 32'hdd2b;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		model[0] = 24'h000063;
		model[1] = 24'h00FFFF;
		model[2] = 24'h30D400;
		model[3] = 24'h0000AE;

		repeat (16) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;

		if (out_valid) begin
			$display("Error: output valid is high right after reset");
			other_errors++;
		end
		check_settings("reset values", model, settings);
		@(negedge clk);
		if (!in_ready) begin
			$display("Error: input ready still low one cycle after reset");
			other_errors++;
		end
		@(posedge clk);
		#DRIVE_DLY;

		version_test();
		query_reset_test();
		set_query_test();
		bad_input_test();
		soak_test();
		finish_run();
	end

endmodule

`default_nettype wire

//--- sources.f
rtl/cfg_pkg.sv
rtl/frame_rx.sv
rtl/param_slot.sv
rtl/ack_generator.sv
rtl/msg_fifo.sv
rtl/cmd_engine.sv
rtl/cfg_top.sv
verif/tb_cfg_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cfg_top
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
